// ==== build.f ====
+incdir+tb
design/stq_pkg.sv
design/stq_commit_track.sv
design/stq_operand_track.sv
design/stq_entry_fsm.sv
design/stq_snoop_resp.sv
design/stq_entry.sv
tb/stq_entry_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the store-queue entry testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module stq_entry_tb -f build.f -o stq_sim

out=$(./obj_dir/stq_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

// ==== tb/stq_ref.svh ====
`ifndef STQ_REF_SVH
`define STQ_REF_SVH

// expected snoop answer for a store that hits the snooped line

function automatic stq_pkg::line_be_t ref_snoop_be(input stq_pkg::paddr_t paddr,
                                                   input stq_pkg::size_t  size);
  stq_pkg::line_be_t be;
  int                off;
  be  = '0;
  off = int'(paddr % stq_pkg::LINE_B);
  for (int b = 0; b < (1 << size); b++) begin
    be[off + b] = 1'b1;  // aligned so it stays inside the line
  end
  return be;
endfunction

function automatic stq_pkg::line_data_t ref_snoop_data(input stq_pkg::paddr_t paddr,
                                                       input stq_pkg::data_t  data);
  stq_pkg::line_data_t line;
  int                  off;
  line = '0;
  off  = int'(paddr % stq_pkg::LINE_B);
  // whole word lands at the offset
  // bytes beyond the line end are lost
  for (int b = 0; b < stq_pkg::XLEN / 8; b++) begin
    if (off + b < stq_pkg::LINE_B) begin
      line[(off + b) * 8 +: 8] = data[b * 8 +: 8];
    end
  end
  return line;
endfunction

`endif

// ==== tb/stq_entry_tb.sv ====
`timescale 1ns/1ns

module stq_entry_tb;

  localparam int          MAX_CYCLES = 2000;  // six tests of ~60 cycles with wide margin
  localparam int          WAIT_LIMIT = 50;
  localparam logic [31:0] SEED       = 32'hbd2f_5f89;
  localparam int          SIG_READY  = 0;
  localparam int          SIG_STBUF  = 1;
  localparam int          SIG_UC     = 2;
  localparam int          SIG_FINISH = 3;

  logic                i_clk = 1'b0;
  logic                i_reset_n;
  logic                i_disp_load;
  stq_pkg::cmt_id_t    i_disp_cmt_id;
  stq_pkg::grp_id_t    i_disp_grp_id;
  stq_pkg::br_mask_t   i_disp_br_mask;
  stq_pkg::rnid_t      i_disp_rs1_rnid;
  logic                i_disp_rs1_ready;
  stq_pkg::rnid_t      i_disp_rs2_rnid;
  logic                i_disp_rs2_ready;
  logic                i_phy_wr_valid [stq_pkg::PHY_WR_NUM];
  stq_pkg::rnid_t      i_phy_wr_rnid  [stq_pkg::PHY_WR_NUM];
  stq_pkg::data_t      i_phy_wr_data  [stq_pkg::PHY_WR_NUM];
  logic                o_entry_ready;
  logic                i_entry_picked;
  logic                i_ex1_valid;
  stq_pkg::ex1_haz_t   i_ex1_haz;
  stq_pkg::paddr_t     i_ex1_paddr;
  stq_pkg::size_t      i_ex1_size;
  logic                i_ex1_uc;
  logic                i_tlb_resolve;
  logic                i_commit_valid;
  stq_pkg::cmt_id_t    i_commit_cmt_id;
  stq_pkg::grp_id_t    i_commit_grp_id;
  stq_pkg::grp_id_t    i_commit_dead_grp;
  logic                i_br_upd_valid;
  stq_pkg::brtag_t     i_br_upd_tag;
  logic                i_br_upd_mispredict;
  logic                o_stbuf_req_valid;
  logic                i_stbuf_accept;
  logic                o_uc_write_req_valid;
  logic                i_uc_write_accept;
  stq_pkg::paddr_t     o_paddr;
  stq_pkg::size_t      o_size;
  stq_pkg::data_t      o_st_data;
  logic                i_stq_outptr_valid;
  logic                o_st_finish;
  logic                i_snoop_req_valid;
  stq_pkg::paddr_t     i_snoop_paddr;
  logic                o_snoop_resp_valid;
  stq_pkg::line_be_t   o_snoop_resp_be;
  stq_pkg::line_data_t o_snoop_resp_data;

  // current store
  stq_pkg::cmt_id_t    s_cmt;
  stq_pkg::grp_id_t    s_grp;
  stq_pkg::rnid_t      s_rs1;
  stq_pkg::rnid_t      s_rs2;
  stq_pkg::data_t      s_data;
  stq_pkg::paddr_t     s_paddr;
  stq_pkg::size_t      s_size;

  stq_pkg::line_be_t   exp_be_q[$];
  stq_pkg::line_data_t exp_data_q[$];
  logic                snoop_sent = 1'b0;
  string               test_name = "reset";
  int                  errors = 0;
  int                  test_err0 = 0;
  int                  n_tests = 0;
  int                  n_failed = 0;
  int                  cycles = 0;

  `include "stq_ref.svh"

  stq_entry dut0 (.*);

  always #4 i_clk = ~i_clk;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch in %s: %s expected %b, actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_size(input string what, input stq_pkg::size_t exp,
                            input stq_pkg::size_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: %s expected %0d, actual %0d", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_data(input string what, input stq_pkg::data_t exp,
                            input stq_pkg::data_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_paddr(input string what, input stq_pkg::paddr_t exp,
                             input stq_pkg::paddr_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_be(input string what, input stq_pkg::line_be_t exp,
                          input stq_pkg::line_be_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_line(input string what, input stq_pkg::line_data_t exp,
                            input stq_pkg::line_data_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: %s expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // snoop responses one cycle behind the request
  always @(posedge i_clk) begin
    snoop_sent <= i_snoop_req_valid;
  end

  always @(negedge i_clk) begin
    if (i_reset_n) begin
      check_bit("o_snoop_resp_valid", snoop_sent, o_snoop_resp_valid);
      if (snoop_sent && exp_be_q.size() == 0) begin
        $display("Error in %s: snoop response with no request recorded", test_name);
        errors++;
      end else if (snoop_sent) begin
        check_be("o_snoop_resp_be", exp_be_q.pop_front(), o_snoop_resp_be);
        check_line("o_snoop_resp_data", exp_data_q.pop_front(), o_snoop_resp_data);
      end
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Error: run reached %0d cycles in test %s without finishing",
               MAX_CYCLES, test_name);
      $display("Simulation failed");
      $finish;
    end
  end

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  task automatic clear_inputs();
    i_reset_n           = 1'b0;
    i_disp_load         = 1'b0;
    i_disp_cmt_id       = '0;
    i_disp_grp_id       = '0;
    i_disp_br_mask      = '0;
    i_disp_rs1_rnid     = '0;
    i_disp_rs1_ready    = 1'b0;
    i_disp_rs2_rnid     = '0;
    i_disp_rs2_ready    = 1'b0;
    for (int p = 0; p < stq_pkg::PHY_WR_NUM; p++) begin
      i_phy_wr_valid[p] = 1'b0;
      i_phy_wr_rnid[p]  = '0;
      i_phy_wr_data[p]  = '0;
    end
    i_entry_picked      = 1'b0;
    i_ex1_valid         = 1'b0;
    i_ex1_haz           = stq_pkg::EX1_HAZ_NONE;
    i_ex1_paddr         = '0;
    i_ex1_size          = '0;
    i_ex1_uc            = 1'b0;
    i_tlb_resolve       = 1'b0;
    i_commit_valid      = 1'b0;
    i_commit_cmt_id     = '0;
    i_commit_grp_id     = '0;
    i_commit_dead_grp   = '0;
    i_br_upd_valid      = 1'b0;
    i_br_upd_tag        = '0;
    i_br_upd_mispredict = 1'b0;
    i_stbuf_accept      = 1'b0;
    i_uc_write_accept   = 1'b0;
    i_stq_outptr_valid  = 1'b0;
    i_snoop_req_valid   = 1'b0;
    i_snoop_paddr       = '0;
  endtask

  function automatic logic out_sig(input int sel);
    case (sel)
      SIG_READY: return o_entry_ready;
      SIG_STBUF: return o_stbuf_req_valid;
      SIG_UC:    return o_uc_write_req_valid;
      default:   return o_st_finish;
    endcase
  endfunction

  // returns on the falling edge after the signal was seen high
  task automatic wait_high(input int sel, input string what);
    int n;
    n = 0;
    #1;
    while (!out_sig(sel) && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      #1;
      n++;
    end
    if (!out_sig(sel)) begin
      $display("Error in %s: %s never came within %0d cycles", test_name, what, WAIT_LIMIT);
      errors++;
    end
    @(negedge i_clk);
  endtask

  task automatic new_store();
    s_cmt   = stq_pkg::cmt_id_t'($urandom);
    s_grp   = stq_pkg::grp_id_t'(1 << $urandom_range(3, 0));
    s_rs1   = stq_pkg::rnid_t'($urandom);
    s_rs2   = s_rs1 ^ stq_pkg::rnid_t'(6'h2a);  // never equal to rs1
    s_data  = stq_pkg::data_t'($urandom);
    s_size  = stq_pkg::size_t'($urandom_range(2, 0));
    s_paddr = stq_pkg::paddr_t'($urandom) & ~((32'd1 << s_size) - 32'd1);
  endtask

  task automatic dispatch_store(input logic rs1_rdy, input logic rs2_rdy,
                                input stq_pkg::br_mask_t mask);
    i_disp_load      = 1'b1;
    i_disp_cmt_id    = s_cmt;
    i_disp_grp_id    = s_grp;
    i_disp_br_mask   = mask;
    i_disp_rs1_rnid  = s_rs1;
    i_disp_rs1_ready = rs1_rdy;
    i_disp_rs2_rnid  = s_rs2;
    i_disp_rs2_ready = rs2_rdy;
    if (rs2_rdy) begin
      i_phy_wr_valid[0] = 1'b1;  // data written back in the dispatch cycle
      i_phy_wr_rnid[0]  = s_rs2;
      i_phy_wr_data[0]  = s_data;
    end
    @(negedge i_clk);
    i_disp_load       = 1'b0;
    i_phy_wr_valid[0] = 1'b0;
  endtask

  task automatic write_reg(input int port, input stq_pkg::rnid_t rnid,
                           input stq_pkg::data_t data);
    i_phy_wr_valid[port] = 1'b1;
    i_phy_wr_rnid[port]  = rnid;
    i_phy_wr_data[port]  = data;
    @(negedge i_clk);
    i_phy_wr_valid[port] = 1'b0;
  endtask

  task automatic pick();
    i_entry_picked = 1'b1;  // only counts with o_entry_ready
    wait_high(SIG_READY, "o_entry_ready");
    i_entry_picked = 1'b0;
  endtask

  task automatic ex1_update(input stq_pkg::ex1_haz_t haz, input logic uc);
    i_ex1_valid = 1'b1;
    i_ex1_haz   = haz;
    i_ex1_paddr = s_paddr;
    i_ex1_size  = s_size;
    i_ex1_uc    = uc;
    @(negedge i_clk);
    i_ex1_valid = 1'b0;
  endtask

  task automatic commit_store(input logic dead);
    i_commit_valid    = 1'b1;
    i_commit_cmt_id   = s_cmt;
    i_commit_grp_id   = dead ? '0 : s_grp;
    i_commit_dead_grp = dead ? s_grp : '0;
    @(negedge i_clk);
    i_commit_valid = 1'b0;
  endtask

  task automatic finish_request(input logic uc, input int hold);
    if (uc) begin
      wait_high(SIG_UC, "o_uc_write_req_valid");
    end else begin
      wait_high(SIG_STBUF, "o_stbuf_req_valid");
    end
    repeat (hold) begin
      check_bit("request under back-pressure", 1'b1,
                uc ? o_uc_write_req_valid : o_stbuf_req_valid);
      check_bit("o_st_finish without accept", 1'b0, o_st_finish);
      @(negedge i_clk);
    end
    if (uc) begin
      i_uc_write_accept = 1'b1;
    end else begin
      i_stbuf_accept = 1'b1;
    end
    #1;
    check_bit("other request port", 1'b0, uc ? o_stbuf_req_valid : o_uc_write_req_valid);
    check_paddr("o_paddr", s_paddr, o_paddr);
    check_size("o_size", s_size, o_size);
    check_data("o_st_data", s_data, o_st_data);
    check_bit("o_st_finish on accept", 1'b1, o_st_finish);
    @(negedge i_clk);
    check_bit("o_st_finish after accept", 1'b0, o_st_finish);
    check_bit("request after accept", 1'b0, o_stbuf_req_valid | o_uc_write_req_valid);
    i_stbuf_accept    = 1'b0;
    i_uc_write_accept = 1'b0;
  endtask

  task automatic full_store(input logic uc, input int hold);
    new_store();
    dispatch_store(1'b1, 1'b1, '0);
    pick();
    ex1_update(stq_pkg::EX1_HAZ_NONE, uc);
    commit_store(1'b0);
    finish_request(uc, hold);
  endtask

  // flushed entry must stay quiet until it reaches the queue head
  task automatic drain_dead();
    repeat (4) begin
      check_bit("request after flush", 1'b0, o_stbuf_req_valid | o_uc_write_req_valid);
      check_bit("o_st_finish before outptr", 1'b0, o_st_finish);
      @(negedge i_clk);
    end
    i_stq_outptr_valid = 1'b1;
    wait_high(SIG_FINISH, "o_st_finish from the flushed entry");
    i_stq_outptr_valid = 1'b0;
    check_bit("o_st_finish after drain", 1'b0, o_st_finish);
  endtask

  task automatic mispredict_store();
    stq_pkg::brtag_t tag;
    tag = stq_pkg::brtag_t'($urandom_range(7, 0));
    new_store();
    dispatch_store(1'b1, 1'b1, stq_pkg::br_mask_t'($urandom) | (stq_pkg::br_mask_t'(1) << tag));
    pick();
    i_br_upd_valid      = 1'b1;
    i_br_upd_tag        = tag;
    i_br_upd_mispredict = 1'b1;
    @(negedge i_clk);
    i_br_upd_valid      = 1'b0;
    i_br_upd_mispredict = 1'b0;
  endtask

  task automatic snoop(input stq_pkg::paddr_t addr, input stq_pkg::line_be_t be,
                       input stq_pkg::line_data_t data);
    i_snoop_req_valid = 1'b1;
    i_snoop_paddr     = addr;
    exp_be_q.push_back(be);
    exp_data_q.push_back(data);
    @(negedge i_clk);
    i_snoop_req_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (errors == test_err0) begin
      $display("test %-10s ok", test_name);
    end else begin
      n_failed++;
      $display("test %-10s FAILED with %0d errors", test_name, errors - test_err0);
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    void'($urandom(SEED));
    clear_inputs();
    repeat (10) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    start_test("cacheable");
    full_store(1'b0, 3);
    full_store(1'b0, 0);  // second dispatch into the freed entry
    end_test();

    start_test("wakeup");
    new_store();
    dispatch_store(1'b0, 1'b0, '0);
    repeat (3) begin
      #1;
      check_bit("o_entry_ready before rs1 write", 1'b0, o_entry_ready);
      @(negedge i_clk);
    end
    write_reg(1, s_rs1, stq_pkg::data_t'($urandom));
    pick();
    ex1_update(stq_pkg::EX1_HAZ_NONE, 1'b0);
    commit_store(1'b0);
    repeat (3) begin
      check_bit("request before rs2 write", 1'b0, o_stbuf_req_valid | o_uc_write_req_valid);
      @(negedge i_clk);
    end
    write_reg(0, s_rs2, s_data);
    finish_request(1'b0, 0);
    end_test();

    start_test("tlb_miss");
    new_store();
    dispatch_store(1'b1, 1'b1, '0);
    pick();
    ex1_update(stq_pkg::EX1_HAZ_TLB_MISS, 1'b0);
    repeat (4) begin
      #1;
      check_bit("o_entry_ready during tlb miss", 1'b0, o_entry_ready);
      @(negedge i_clk);
    end
    i_tlb_resolve = 1'b1;
    @(negedge i_clk);
    i_tlb_resolve = 1'b0;
    pick();
    ex1_update(stq_pkg::EX1_HAZ_NONE, 1'b0);
    commit_store(1'b0);
    finish_request(1'b0, 1);
    end_test();

    start_test("uncached");
    full_store(1'b1, 2);
    end_test();

    start_test("flush");
    mispredict_store();
    drain_dead();
    new_store();
    dispatch_store(1'b1, 1'b1, '0);
    pick();
    ex1_update(stq_pkg::EX1_HAZ_NONE, 1'b0);
    commit_store(1'b1);  // group killed at commit
    drain_dead();
    end_test();

    start_test("snoop");
    new_store();
    dispatch_store(1'b1, 1'b1, '0);
    pick();
    ex1_update(stq_pkg::EX1_HAZ_NONE, 1'b0);
    commit_store(1'b0);
    wait_high(SIG_STBUF, "o_stbuf_req_valid");
    snoop(s_paddr ^ stq_pkg::paddr_t'($urandom_range(15, 0)),
          ref_snoop_be(s_paddr, s_size), ref_snoop_data(s_paddr, s_data));
    snoop(s_paddr ^ stq_pkg::paddr_t'(stq_pkg::LINE_B), '0, '0);  // neighbour line
    @(negedge i_clk);
    finish_request(1'b0, 0);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== design/stq_entry.sv ====
`timescale 1ns/1ns

module stq_entry (
  input  logic                i_clk,
  input  logic                i_reset_n,
  // dispatch
  input  logic                i_disp_load,
  input  stq_pkg::cmt_id_t    i_disp_cmt_id,
  input  stq_pkg::grp_id_t    i_disp_grp_id,
  input  stq_pkg::br_mask_t   i_disp_br_mask,
  input  stq_pkg::rnid_t      i_disp_rs1_rnid,
  input  logic                i_disp_rs1_ready,
  input  stq_pkg::rnid_t      i_disp_rs2_rnid,
  input  logic                i_disp_rs2_ready,
  input  logic                i_phy_wr_valid [stq_pkg::PHY_WR_NUM],
  input  stq_pkg::rnid_t      i_phy_wr_rnid  [stq_pkg::PHY_WR_NUM],
  input  stq_pkg::data_t      i_phy_wr_data  [stq_pkg::PHY_WR_NUM],
  // issue and ex1
  output logic                o_entry_ready,
  input  logic                i_entry_picked,
  input  logic                i_ex1_valid,
  input  stq_pkg::ex1_haz_t   i_ex1_haz,
  input  stq_pkg::paddr_t     i_ex1_paddr,
  input  stq_pkg::size_t      i_ex1_size,
  input  logic                i_ex1_uc,
  input  logic                i_tlb_resolve,
  // commit and branch
  input  logic                i_commit_valid,
  input  stq_pkg::cmt_id_t    i_commit_cmt_id,
  input  stq_pkg::grp_id_t    i_commit_grp_id,
  input  stq_pkg::grp_id_t    i_commit_dead_grp,
  input  logic                i_br_upd_valid,
  input  stq_pkg::brtag_t     i_br_upd_tag,
  input  logic                i_br_upd_mispredict,
  // memory side
  output logic                o_stbuf_req_valid,
  input  logic                i_stbuf_accept,
  output logic                o_uc_write_req_valid,
  input  logic                i_uc_write_accept,
  output stq_pkg::paddr_t     o_paddr,
  output stq_pkg::size_t      o_size,
  output stq_pkg::data_t      o_st_data,
  input  logic                i_stq_outptr_valid,
  output logic                o_st_finish,
  // snoop
  input  logic                i_snoop_req_valid,
  input  stq_pkg::paddr_t     i_snoop_paddr,
  output logic                o_snoop_resp_valid,
  output stq_pkg::line_be_t   o_snoop_resp_be,
  output stq_pkg::line_data_t o_snoop_resp_data
);

  logic                w_flush;
  logic                w_disp_flush;
  logic                w_commit_ok;
  logic                w_busy;
  logic                w_rs1_ready;
  logic                w_rs2_ready;
  stq_pkg::data_t      w_st_data;
  stq_pkg::stq_state_t w_state;
  stq_pkg::paddr_t     w_paddr;
  logic                w_paddr_valid;
  stq_pkg::size_t      w_size;

  assign o_paddr   = w_paddr;
  assign o_size    = w_size;
  assign o_st_data = w_st_data;

  stq_commit_track u_commit_track (
    .i_clk, .i_reset_n,
    .i_disp_load, .i_disp_cmt_id, .i_disp_grp_id, .i_disp_br_mask,
    .i_busy (w_busy),
    .i_commit_valid, .i_commit_cmt_id, .i_commit_grp_id, .i_commit_dead_grp,
    .i_br_upd_valid, .i_br_upd_tag, .i_br_upd_mispredict,
    .o_flush (w_flush), .o_disp_flush (w_disp_flush), .o_commit_ok (w_commit_ok)
  );

  stq_operand_track u_operand_track (
    .i_clk, .i_reset_n,
    .i_disp_load, .i_disp_rs1_rnid, .i_disp_rs1_ready, .i_disp_rs2_rnid, .i_disp_rs2_ready,
    .i_phy_wr_valid, .i_phy_wr_rnid, .i_phy_wr_data,
    .o_rs1_ready (w_rs1_ready), .o_rs2_ready (w_rs2_ready), .o_st_data (w_st_data)
  );

  stq_entry_fsm u_entry_fsm (
    .i_clk, .i_reset_n,
    .i_disp_load,
    .i_flush (w_flush), .i_disp_flush (w_disp_flush), .i_commit_ok (w_commit_ok),
    .i_rs1_ready (w_rs1_ready), .i_rs2_ready (w_rs2_ready),
    .i_entry_picked,
    .i_ex1_valid, .i_ex1_haz, .i_ex1_paddr, .i_ex1_size, .i_ex1_uc,
    .i_tlb_resolve,
    .i_stbuf_accept, .i_uc_write_accept, .i_stq_outptr_valid,
    .o_busy (w_busy), .o_entry_ready, .o_stbuf_req_valid, .o_uc_write_req_valid,
    .o_st_finish,
    .o_state (w_state), .o_paddr (w_paddr), .o_paddr_valid (w_paddr_valid),
    .o_size (w_size)
  );

  stq_snoop_resp u_snoop_resp (
    .i_clk, .i_reset_n,
    .i_state (w_state), .i_paddr (w_paddr), .i_paddr_valid (w_paddr_valid),
    .i_size (w_size), .i_st_data (w_st_data),
    .i_snoop_req_valid, .i_snoop_paddr,
    .o_snoop_resp_valid, .o_snoop_resp_be, .o_snoop_resp_data
  );

endmodule

// ==== design/stq_snoop_resp.sv ====
`timescale 1ns/1ns

module stq_snoop_resp (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  stq_pkg::stq_state_t i_state,
  input  stq_pkg::paddr_t     i_paddr,
  input  logic                i_paddr_valid,
  input  stq_pkg::size_t      i_size,
  input  stq_pkg::data_t      i_st_data,
  input  logic                i_snoop_req_valid,
  input  stq_pkg::paddr_t     i_snoop_paddr,
  output logic                o_snoop_resp_valid,
  output stq_pkg::line_be_t   o_snoop_resp_be,
  output stq_pkg::line_data_t o_snoop_resp_data
);

  logic [stq_pkg::LINE_OFF_W-1:0] w_off;
  logic                           w_hit;
  stq_pkg::line_be_t              w_be;
  stq_pkg::line_data_t            w_data;

  assign w_off = i_paddr[stq_pkg::LINE_OFF_W-1:0];
  assign w_hit = (i_state == stq_pkg::COMMIT) & i_paddr_valid &
                 (i_paddr[stq_pkg::PADDR_W-1:stq_pkg::LINE_OFF_W] ==
                  i_snoop_paddr[stq_pkg::PADDR_W-1:stq_pkg::LINE_OFF_W]);

  // (1 << size) bytes from the line offset
  assign w_be   = stq_pkg::line_be_t'((1 << (1 << i_size)) - 1) << w_off;
  assign w_data = stq_pkg::line_data_t'(i_st_data) << {w_off, 3'b000};

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_snoop_resp_valid <= 1'b0;
    end else begin
      o_snoop_resp_valid <= i_snoop_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_snoop_resp_be   <= w_hit ? w_be : '0;
    o_snoop_resp_data <= w_hit ? w_data : '0;
  end

  a_snoop_resp : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_snoop_req_valid |=> o_snoop_resp_valid);

endmodule

// ==== design/stq_entry_fsm.sv ====
`timescale 1ns/1ns

module stq_entry_fsm (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_disp_load,
  input  logic                i_flush,
  input  logic                i_disp_flush,
  input  logic                i_commit_ok,
  input  logic                i_rs1_ready,
  input  logic                i_rs2_ready,
  input  logic                i_entry_picked,
  input  logic                i_ex1_valid,
  input  stq_pkg::ex1_haz_t   i_ex1_haz,
  input  stq_pkg::paddr_t     i_ex1_paddr,
  input  stq_pkg::size_t      i_ex1_size,
  input  logic                i_ex1_uc,
  input  logic                i_tlb_resolve,
  input  logic                i_stbuf_accept,
  input  logic                i_uc_write_accept,
  input  logic                i_stq_outptr_valid,
  output logic                o_busy,
  output logic                o_entry_ready,
  output logic                o_stbuf_req_valid,
  output logic                o_uc_write_req_valid,
  output logic                o_st_finish,
  output stq_pkg::stq_state_t o_state,
  output stq_pkg::paddr_t     o_paddr,
  output logic                o_paddr_valid,
  output stq_pkg::size_t      o_size
);

  stq_pkg::stq_state_t r_state;
  stq_pkg::stq_state_t w_state_next;
  stq_pkg::paddr_t     r_paddr;
  stq_pkg::size_t      r_size;
  logic                r_uc;
  logic                r_paddr_valid;
  logic                w_ex1_take;
  logic                w_tlb_miss;
  logic                w_in_commit;

  assign w_ex1_take  = (r_state == stq_pkg::ISSUED) & i_ex1_valid & ~i_flush;
  assign w_tlb_miss  = (i_ex1_haz == stq_pkg::EX1_HAZ_TLB_MISS);
  assign w_in_commit = (r_state == stq_pkg::COMMIT);

  assign o_busy        = (r_state != stq_pkg::INIT);
  assign o_entry_ready = (r_state == stq_pkg::ISSUE_WAIT) & i_rs1_ready & ~i_flush;

  // ------------------------------
  // memory side requests
  // ------------------------------
  assign o_stbuf_req_valid    = w_in_commit & ~r_uc;
  assign o_uc_write_req_valid = w_in_commit & r_uc;
  assign o_st_finish = o_stbuf_req_valid & i_stbuf_accept |
                       o_uc_write_req_valid & i_uc_write_accept |
                       (r_state == stq_pkg::DEAD) & i_stq_outptr_valid;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      stq_pkg::INIT: begin
        if (i_disp_load) begin
          w_state_next = i_disp_flush ? stq_pkg::DEAD : stq_pkg::ISSUE_WAIT;
        end
      end
      stq_pkg::ISSUE_WAIT: begin
        if (i_flush) begin
          w_state_next = stq_pkg::DEAD;
        end else if (o_entry_ready && i_entry_picked) begin
          w_state_next = stq_pkg::ISSUED;
        end
      end
      stq_pkg::ISSUED: begin
        if (i_flush) begin
          w_state_next = stq_pkg::DEAD;
        end else if (i_ex1_valid) begin
          w_state_next = w_tlb_miss ? stq_pkg::TLB_HAZ : stq_pkg::WAIT_COMMIT;
        end
      end
      stq_pkg::TLB_HAZ: begin
        if (i_flush) begin
          w_state_next = stq_pkg::DEAD;
        end else if (i_tlb_resolve) begin
          w_state_next = stq_pkg::ISSUE_WAIT;  // replay through issue
        end
      end
      stq_pkg::WAIT_COMMIT: begin
        if (i_flush) begin
          w_state_next = stq_pkg::DEAD;
        end else if (i_commit_ok) begin
          w_state_next = i_rs2_ready ? stq_pkg::COMMIT : stq_pkg::WAIT_ST_DATA;
        end
      end
      stq_pkg::WAIT_ST_DATA: begin
        if (i_flush) begin
          w_state_next = stq_pkg::DEAD;
        end else if (i_rs2_ready) begin
          w_state_next = stq_pkg::COMMIT;
        end
      end
      stq_pkg::COMMIT: begin
        if (o_st_finish) begin
          w_state_next = stq_pkg::INIT;
        end
      end
      stq_pkg::DEAD: begin
        if (o_st_finish) begin
          w_state_next = stq_pkg::INIT;
        end
      end
      default: w_state_next = stq_pkg::INIT;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state       <= stq_pkg::INIT;
      r_paddr_valid <= 1'b0;
    end else begin
      r_state <= w_state_next;
      if (i_disp_load) begin
        r_paddr_valid <= 1'b0;
      end else if (w_ex1_take) begin
        r_paddr_valid <= ~w_tlb_miss;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_ex1_take) begin
      r_paddr <= i_ex1_paddr;
      r_size  <= i_ex1_size;
      r_uc    <= i_ex1_uc;
    end
  end

  assign o_state       = r_state;
  assign o_paddr       = r_paddr;
  assign o_paddr_valid = r_paddr_valid;
  assign o_size        = r_size;

  a_disp_in_init : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_load |-> (r_state == stq_pkg::INIT));

  // one port per store
  a_req_onehot : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0({o_stbuf_req_valid, o_uc_write_req_valid}));

endmodule

// ==== design/stq_operand_track.sv ====
`timescale 1ns/1ns

module stq_operand_track (
  input  logic           i_clk,
  input  logic           i_reset_n,
  input  logic           i_disp_load,
  input  stq_pkg::rnid_t i_disp_rs1_rnid,
  input  logic           i_disp_rs1_ready,
  input  stq_pkg::rnid_t i_disp_rs2_rnid,
  input  logic           i_disp_rs2_ready,
  input  logic           i_phy_wr_valid [stq_pkg::PHY_WR_NUM],
  input  stq_pkg::rnid_t i_phy_wr_rnid  [stq_pkg::PHY_WR_NUM],
  input  stq_pkg::data_t i_phy_wr_data  [stq_pkg::PHY_WR_NUM],
  output logic           o_rs1_ready,
  output logic           o_rs2_ready,
  output stq_pkg::data_t o_st_data
);

  stq_pkg::rnid_t r_rs1_rnid;
  stq_pkg::rnid_t r_rs2_rnid;
  logic           r_rs1_ready;
  logic           r_rs2_ready;
  logic           r_rs2_got;
  stq_pkg::data_t r_st_data;
  stq_pkg::rnid_t w_rs1_rnid;
  stq_pkg::rnid_t w_rs2_rnid;
  logic           w_rs1_hit;
  logic           w_rs2_hit;
  logic           w_rs2_capture;
  stq_pkg::data_t w_rs2_wr_data;

  // compare against the incoming tags in the dispatch cycle
  assign w_rs1_rnid = i_disp_load ? i_disp_rs1_rnid : r_rs1_rnid;
  assign w_rs2_rnid = i_disp_load ? i_disp_rs2_rnid : r_rs2_rnid;

  always_comb begin
    w_rs1_hit     = 1'b0;
    w_rs2_hit     = 1'b0;
    w_rs2_wr_data = '0;
    for (int p = 0; p < stq_pkg::PHY_WR_NUM; p++) begin
      if (i_phy_wr_valid[p] && (i_phy_wr_rnid[p] == w_rs1_rnid)) begin
        w_rs1_hit = 1'b1;
      end
      if (i_phy_wr_valid[p] && (i_phy_wr_rnid[p] == w_rs2_rnid)) begin
        w_rs2_hit     = 1'b1;
        w_rs2_wr_data = i_phy_wr_data[p];
      end
    end
  end

  assign w_rs2_capture = w_rs2_hit & (i_disp_load | ~r_rs2_got);  // first match only

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rs1_rnid  <= '0;
      r_rs2_rnid  <= '0;
      r_rs1_ready <= 1'b0;
      r_rs2_ready <= 1'b0;
      r_rs2_got   <= 1'b0;
    end else if (i_disp_load) begin
      r_rs1_rnid  <= i_disp_rs1_rnid;
      r_rs2_rnid  <= i_disp_rs2_rnid;
      r_rs1_ready <= i_disp_rs1_ready | w_rs1_hit;
      r_rs2_ready <= i_disp_rs2_ready | w_rs2_hit;
      r_rs2_got   <= w_rs2_hit;
    end else begin
      r_rs1_ready <= r_rs1_ready | w_rs1_hit;
      r_rs2_ready <= r_rs2_ready | w_rs2_hit;
      r_rs2_got   <= r_rs2_got | w_rs2_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_rs2_capture) begin
      r_st_data <= w_rs2_wr_data;
    end
  end

  assign o_rs1_ready = r_rs1_ready;
  assign o_rs2_ready = r_rs2_ready;
  assign o_st_data   = r_st_data;

endmodule

// ==== design/stq_commit_track.sv ====
`timescale 1ns/1ns

module stq_commit_track (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_disp_load,
  input  stq_pkg::cmt_id_t  i_disp_cmt_id,
  input  stq_pkg::grp_id_t  i_disp_grp_id,
  input  stq_pkg::br_mask_t i_disp_br_mask,
  input  logic              i_busy,
  input  logic              i_commit_valid,
  input  stq_pkg::cmt_id_t  i_commit_cmt_id,
  input  stq_pkg::grp_id_t  i_commit_grp_id,
  input  stq_pkg::grp_id_t  i_commit_dead_grp,
  input  logic              i_br_upd_valid,
  input  stq_pkg::brtag_t   i_br_upd_tag,
  input  logic              i_br_upd_mispredict,
  output logic              o_flush,
  output logic              o_disp_flush,
  output logic              o_commit_ok
);

  stq_pkg::cmt_id_t  r_cmt_id;
  stq_pkg::grp_id_t  r_grp_id;
  stq_pkg::br_mask_t r_br_mask;
  stq_pkg::br_mask_t w_br_mask_next;
  logic              w_cmt_match;
  logic              w_grp_dead;
  logic              w_grp_done;
  logic              w_br_kill;

  assign w_cmt_match = i_commit_valid & (i_commit_cmt_id == r_cmt_id);
  assign w_grp_dead  = |(r_grp_id & i_commit_dead_grp);
  assign w_grp_done  = |(r_grp_id & i_commit_grp_id);
  assign w_br_kill   = i_br_upd_valid & i_br_upd_mispredict & r_br_mask[i_br_upd_tag];

  assign o_flush      = i_busy & (w_cmt_match & w_grp_dead | w_br_kill);
  assign o_commit_ok  = i_busy & w_cmt_match & w_grp_done & ~w_grp_dead;
  // mispredict racing the dispatch itself
  assign o_disp_flush = i_disp_load & i_br_upd_valid & i_br_upd_mispredict &
                        i_disp_br_mask[i_br_upd_tag];

  always_comb begin
    w_br_mask_next = i_disp_load ? i_disp_br_mask : r_br_mask;
    if (i_br_upd_valid) begin
      w_br_mask_next[i_br_upd_tag] = 1'b0;  // resolved either way
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_br_mask <= '0;
    end else begin
      r_br_mask <= w_br_mask_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_disp_load) begin
      r_cmt_id <= i_disp_cmt_id;
      r_grp_id <= i_disp_grp_id;
    end
  end

  // a committing store has no unresolved branch left that could kill it
  a_flush_vs_commit : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_flush && o_commit_ok));

endmodule

// ==== design/stq_pkg.sv ====
package stq_pkg;

  localparam int CMT_ID_W   = 5;
  localparam int GRP_W      = 4;
  localparam int RNID_W     = 6;
  localparam int BR_TAG_NUM = 8;
  localparam int XLEN       = 32;
  localparam int PADDR_W    = 32;
  localparam int LINE_B     = 16;
  localparam int PHY_WR_NUM = 2;

  // derived widths
  localparam int BR_TAG_W   = $clog2(BR_TAG_NUM);
  localparam int LINE_OFF_W = $clog2(LINE_B);

  typedef logic [CMT_ID_W-1:0]   cmt_id_t;
  typedef logic [GRP_W-1:0]      grp_id_t;     // one-hot
  typedef logic [RNID_W-1:0]     rnid_t;
  typedef logic [BR_TAG_NUM-1:0] br_mask_t;
  typedef logic [BR_TAG_W-1:0]   brtag_t;
  typedef logic [XLEN-1:0]       data_t;
  typedef logic [PADDR_W-1:0]    paddr_t;
  typedef logic [1:0]            size_t;       // log2 of byte count
  typedef logic [LINE_B-1:0]     line_be_t;
  typedef logic [LINE_B*8-1:0]   line_data_t;

  // ------------------------------
  // entry states
  // ------------------------------
  typedef enum logic [2:0] {
    INIT,
    ISSUE_WAIT,
    ISSUED,
    TLB_HAZ,
    WAIT_COMMIT,
    WAIT_ST_DATA,
    COMMIT,
    DEAD
  } stq_state_t;

  typedef enum logic {
    EX1_HAZ_NONE,
    EX1_HAZ_TLB_MISS
  } ex1_haz_t;

endpackage
